/* sources.f */
verilog/prbs_pkg.sv
verilog/lfsr_gen.sv
verilog/sym_slicer.sv
verilog/ber_accum.sv
verilog/prbs_ber_top.sv
verif/tb_prbs_ber.sv

/* verif/tb_prbs_ber.sv */
module tb_prbs_ber import prbs_pkg::*; ();

    localparam int HALF_PERIOD       = 20;
    localparam int DRIVE_DLY         = 2;   // input drive after the rising edge
    localparam int RESET_CYCLES      = 16;
    localparam int MID_RESET_CYCLES  = 3;
    localparam int TAIL_CYCLES       = 4;
    localparam int PRE_RESET_STROBES = 301;
    localparam logic [31:0] RNG_SEED = 32'h5b901140;

    // nominal pam4 levels centred between the slicer thresholds
    localparam logic signed [SAMPLE_W-1:0] LVL_00 = -96;
    localparam logic signed [SAMPLE_W-1:0] LVL_01 = -32;
    localparam logic signed [SAMPLE_W-1:0] LVL_11 = 32;
    localparam logic signed [SAMPLE_W-1:0] LVL_10 = 96;

    // each test row runs for two full periods
    localparam int NUM_ROWS   = 5;
    localparam int SPARSE_ROW = 3;
    localparam int GAPPED_ROW = 4;

    string row_name    [NUM_ROWS] = '{"clean", "single", "double", "sparse", "gapped"};
    int    row_pct     [NUM_ROWS] = '{100, 100, 100, 100, 50};  // strobe rate in percent
    int    row_spacing [NUM_ROWS] = '{0, 7, 13, 31, 31};        // 0 means no errors
    int    row_weight  [NUM_ROWS] = '{0, 1, 2, 1, 1};           // bits per corrupted symbol

    localparam int TOTAL_STROBES =
        NUM_ROWS * 2 * LFSR_PERIOD + PRE_RESET_STROBES + LFSR_PERIOD + 1;

    logic                       clk;
    logic                       reset;
    logic                       sample_en;
    logic signed [SAMPLE_W-1:0] sample;
    logic        [SYM_W-1:0]    ref_sym;
    logic                       period_start;
    logic        [ERR_W-1:0]    err_count;
    logic                       result_valid;

    // reference model and window bookkeeping
    logic [LFSR_LEN-1:0] model_state;
    logic [ERR_W-1:0]    win_errs;
    int                  win_strobes;  // strobes since the window opened
    logic                win_open;
    string               win_name;
    logic                report_due;
    logic [ERR_W-1:0]    report_exp;
    string               report_name;
    logic [ERR_W-1:0]    report_log [$];

    int checks_done;
    int mismatches;
    int other_errors;
    int cycle_count;
    int cycle_limit;

    prbs_ber_top u_dut (
        .clk          (clk),
        .reset        (reset),
        .sample_en    (sample_en),
        .sample       (sample),
        .ref_sym      (ref_sym),
        .period_start (period_start),
        .err_count    (err_count),
        .result_valid (result_valid)
    );

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // top bit shifts out and is xored back at each tap
    function automatic logic [LFSR_LEN-1:0] lfsr_step(input logic [LFSR_LEN-1:0] st);
        logic [LFSR_LEN-1:0] nxt;
        nxt = {st[LFSR_LEN-2:0], 1'b0};
        if (st[LFSR_LEN-1]) begin
            nxt = nxt ^ TAPS[LFSR_LEN][LFSR_LEN-1:0];
        end
        return nxt;
    endfunction

    function automatic logic [SYM_W-1:0] sym_of(input logic [LFSR_LEN-1:0] st);
        return {st[LFSR_LEN-1], st[0]};
    endfunction

    // gray levels low to high are 00, 01, 11, 10
    function automatic logic signed [SAMPLE_W-1:0] sym_to_level(input logic [SYM_W-1:0] sym);
        case (sym)
            2'b00:   return LVL_00;
            2'b01:   return LVL_01;
            2'b11:   return LVL_11;
            default: return LVL_10;
        endcase
    endfunction

    // an lsb flip lands on the adjacent level and a double flip two levels away
    function automatic logic [SYM_W-1:0] corrupt_sym(input logic [SYM_W-1:0] sym,
                                                     input int weight);
        if (weight >= 2) begin
            return sym ^ 2'b11;
        end else begin
            return sym ^ 2'b01;
        end
    endfunction

    function automatic int lowest_pct();
        int m;
        m = 100;
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (row_pct[r] < m) begin
                m = row_pct[r];
            end
        end
        return m;
    endfunction

    task automatic check_sym(input string what, input logic [SYM_W-1:0] exp,
                             input logic [SYM_W-1:0] act);
        checks_done++;
        if (act !== exp) begin
            mismatches++;
            $display("MISMATCH %s: expected %b, actual %b", what, exp, act);
        end
    endtask

    task automatic check_count(input string what, input logic [ERR_W-1:0] exp,
                               input logic [ERR_W-1:0] act);
        checks_done++;
        if (act !== exp) begin
            mismatches++;
            $display("MISMATCH %s: expected %0d, actual %0d", what, exp, act);
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        checks_done++;
        if (act !== exp) begin
            mismatches++;
            $display("MISMATCH %s: expected %b, actual %b", what, exp, act);
        end
    endtask

    task automatic print_summary();
        $display("summary: %0d checks, %0d mismatches, %0d other errors, %0d cycles",
                 checks_done, mismatches, other_errors, cycle_count);
    endtask

    // checks what the last edge produced and idles the strobe
    task automatic next_cycle(input string name);
        @(posedge clk);
        #DRIVE_DLY;
        if (result_valid !== report_due) begin
            other_errors++;
            if (report_due) begin
                $display("%s: no result_valid one cycle after the period start strobe",
                         report_name);
            end else begin
                $display("%s: result_valid pulsed without a period boundary", name);
            end
        end else if (report_due) begin
            check_count({report_name, " err_count"}, report_exp, err_count);
        end
        if (result_valid === 1'b1) begin
            report_log.push_back(err_count);
        end
        report_due = 1'b0;
        check_sym({name, " ref_sym"}, sym_of(model_state), ref_sym);
        check_flag({name, " period_start"}, model_state == LFSR_SEED, period_start);
        sample_en = 1'b0;
    endtask

    // applies n strobes at the given rate and corrupts every spacing-th symbol
    task automatic run_strobes(input string name, input int n, input int pct,
                               input int spacing, input int weight);
        int               done;
        logic [SYM_W-1:0] sym;
        logic [SYM_W-1:0] tx_sym;
        bit               hit;
        done = 0;
        while (done < n) begin
            next_cycle(name);
            if ($urandom_range(99) < pct) begin
                sym = sym_of(model_state);
                hit = (spacing > 0) && ((done % spacing) == spacing - 1);
                tx_sym = hit ? corrupt_sym(sym, weight) : sym;
                if (model_state == LFSR_SEED) begin
                    // seed strobe closes the running window
                    if (win_open) begin
                        if (win_strobes != LFSR_PERIOD) begin
                            other_errors++;
                            $display("%s: period start came after %0d strobes instead of %0d",
                                     win_name, win_strobes, LFSR_PERIOD);
                        end
                        report_due  = 1'b1;
                        report_exp  = win_errs;
                        report_name = win_name;
                    end
                    win_errs    = '0;
                    win_strobes = 0;
                    win_open    = 1'b1;
                    win_name    = name;
                end
                if (hit) begin
                    win_errs = win_errs + ERR_W'(weight);
                end
                win_strobes++;
                sample_en   = 1'b1;
                sample      = sym_to_level(tx_sym);
                model_state = lfsr_step(model_state);
                done++;
            end else begin
                sample = SAMPLE_W'($urandom);  // junk that the dut must ignore
            end
        end
    endtask

    task automatic mid_reset_test();
        run_strobes("pre_reset", PRE_RESET_STROBES, 100, 9, 1);
        next_cycle("pre_reset");
        if (err_count == '0) begin
            other_errors++;
            $display("mid_reset: err_count is already zero, its clear cannot be seen");
        end
        reset       = 1'b1;
        model_state = LFSR_SEED;
        win_errs    = '0;
        win_strobes = 0;
        win_open    = 1'b0;
        win_name    = "post_reset";
        repeat (MID_RESET_CYCLES) next_cycle("mid_reset");
        check_count("mid_reset err_count", '0, err_count);
        check_sym("mid_reset ref_sym", sym_of(LFSR_SEED), ref_sym);
        reset = 1'b0;
        // one full window plus the seed strobe that reports it
        run_strobes("post_reset", LFSR_PERIOD + 1, 100, 5, 2);
        next_cycle("post_reset");
    endtask

    // gaps must not change any count
    task automatic compare_gapped();
        if (report_log.size() < 2 * GAPPED_ROW + 2) begin
            other_errors++;
            $display("gapped: only %0d reports seen, cannot compare with sparse",
                     report_log.size());
        end else begin
            for (int k = 0; k < 2; k++) begin
                check_count($sformatf("gapped window %0d vs sparse", k),
                            report_log[2 * SPARSE_ROW + k], report_log[2 * GAPPED_ROW + k]);
            end
        end
    endtask

    initial begin
        cycle_count = 0;
        cycle_limit = TOTAL_STROBES * 100 / lowest_pct() + 200
                      + RESET_CYCLES + MID_RESET_CYCLES + TAIL_CYCLES;
        while (cycle_count <= cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        other_errors++;
        $display("timeout: run did not finish within %0d cycles", cycle_limit);
        print_summary();
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        void'($urandom(RNG_SEED));
        reset        = 1'b1;
        sample_en    = 1'b0;
        sample       = '0;
        model_state  = LFSR_SEED;
        win_errs     = '0;
        win_strobes  = 0;
        win_open     = 1'b0;
        win_name     = "reset";
        report_due   = 1'b0;
        report_exp   = '0;
        report_name  = "";
        checks_done  = 0;
        mismatches   = 0;
        other_errors = 0;

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        reset = 1'b0;

        for (int r = 0; r < NUM_ROWS; r++) begin
            run_strobes(row_name[r], 2 * LFSR_PERIOD, row_pct[r],
                        row_spacing[r], row_weight[r]);
        end
        mid_reset_test();
        compare_gapped();
        repeat (TAIL_CYCLES) next_cycle("tail");

        print_summary();
        if (mismatches == 0 && other_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* verilog/ber_accum.sv */
module ber_accum import prbs_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    input  logic             sample_en,
    input  logic [SYM_W-1:0] ref_sym,
    input  logic             period_start,
    input  logic [SYM_W-1:0] rx_sym,
    input  logic             rx_valid,
    output logic [ERR_W-1:0] err_count,
    output logic             result_valid
);

    localparam int DIST_W = $clog2(SYM_W + 1);

    logic [SYM_W-1:0]  ref_sym_d;  // lines up with rx_sym
    logic [SYM_W-1:0]  diff;
    logic [DIST_W-1:0] bit_errs;
    logic [ERR_W-1:0]  add_errs;
    logic [ERR_W-1:0]  run_count;
    logic              win_open;   // a window has been started since reset
    logic              close_win;

    // reference symbol held for the same strobe the slicer is working on
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ref_sym_d <= '0;
        end else if (sample_en) begin
            ref_sym_d <= ref_sym;
        end
    end

    // hamming distance between reference and received symbol
    always_comb begin
        diff = ref_sym_d ^ rx_sym;
        bit_errs = '0;
        for (int i = 0; i < SYM_W; i++) begin
            bit_errs = bit_errs + DIST_W'(diff[i]);
        end
    end

    // nothing to add unless a decided symbol is present this cycle
    assign add_errs = rx_valid ? ERR_W'(bit_errs) : '0;

    // seed strobe ends the old window and opens the next
    assign close_win = sample_en & period_start;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            run_count <= '0;
            win_open  <= 1'b0;
        end else if (close_win) begin
            // symbol in flight goes into err_count with the old window
            run_count <= '0;
            win_open  <= 1'b1;
        end else begin
            run_count <= run_count + add_errs;
        end
    end

    // the first seed after reset only opens a window
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            err_count    <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= close_win & win_open;
            if (close_win && win_open) begin
                err_count <= run_count + add_errs;  // includes last symbol of window
            end
        end
    end

endmodule

/* verilog/lfsr_gen.sv */
module lfsr_gen import prbs_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                sample_en,
    output logic [LFSR_LEN-1:0] ref_state,
    output logic [SYM_W-1:0]    ref_sym,
    output logic                period_start,
    output logic [LFSR_LEN-1:0] period_count
);

    // feedback mask for the configured length
    localparam logic [31:0] TAP_MASK = TAPS[LFSR_LEN];

    logic [LFSR_LEN-1:0] state;
    logic [LFSR_LEN-1:0] next_state;
    logic                fb;

    // galois step: top bit wraps into bit 0 and into every tapped position
    always_comb begin
        fb = state[LFSR_LEN-1];
        next_state[0] = fb & TAP_MASK[0];
        for (int i = 1; i < LFSR_LEN; i++) begin
            next_state[i] = state[i-1] ^ (fb & TAP_MASK[i]);
        end
    end

    // state only moves on a symbol strobe
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= LFSR_SEED;
        end else if (sample_en) begin
            state <= next_state;
        end
    end

    // position of the current symbol within its period, 1 at the seed
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            period_count <= LFSR_LEN'(1);  // seed is symbol 1
        end else if (sample_en) begin
            if (next_state == LFSR_SEED) begin
                period_count <= LFSR_LEN'(1);
            end else begin
                period_count <= period_count + LFSR_LEN'(1);
            end
        end
    end

    assign ref_state = state;

    // msb and lsb of the state form the two-bit reference symbol
    assign ref_sym = {state[LFSR_LEN-1], state[0]};

    // level, high for as long as the seed is held (gaps included)
    assign period_start = (state == LFSR_SEED);

endmodule

/* verilog/prbs_ber_top.sv */
module prbs_ber_top import prbs_pkg::*; (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       sample_en,
    input  logic signed [SAMPLE_W-1:0] sample,
    output logic        [SYM_W-1:0]    ref_sym,
    output logic                       period_start,
    output logic        [ERR_W-1:0]    err_count,
    output logic                       result_valid
);

    logic [SYM_W-1:0] rx_sym;
    logic             rx_valid;

    // reference pattern, free running on the symbol strobe
    lfsr_gen u_lfsr_gen (
        .clk          (clk),
        .reset        (reset),
        .sample_en    (sample_en),
        .ref_state    (),
        .ref_sym      (ref_sym),
        .period_start (period_start),
        .period_count ()
    );

    // received samples to gray symbols
    sym_slicer u_sym_slicer (
        .clk       (clk),
        .reset     (reset),
        .sample_en (sample_en),
        .sample    (sample),
        .rx_sym    (rx_sym),
        .rx_valid  (rx_valid)
    );

    // compare and count per period
    ber_accum u_ber_accum (
        .clk          (clk),
        .reset        (reset),
        .sample_en    (sample_en),
        .ref_sym      (ref_sym),
        .period_start (period_start),
        .rx_sym       (rx_sym),
        .rx_valid     (rx_valid),
        .err_count    (err_count),
        .result_valid (result_valid)
    );

endmodule

/* verilog/prbs_pkg.sv */
package prbs_pkg;

    // generator length, cut down so one full period fits in simulation
    localparam int LFSR_LEN    = 10;
    localparam int LFSR_PERIOD = (1 << LFSR_LEN) - 1;

    // reset state, also the state that marks the start of each period
    localparam logic [LFSR_LEN-1:0] LFSR_SEED = LFSR_LEN'(1);

    // galois feedback masks indexed by register length
    // bit i set means the feedback bit is xored into state bit i
    // bit 0 stands for the constant term and is always set on valid rows
    localparam logic [31:0] TAPS [0:32] = '{
        32'h0000_0000,  // 0, invalid
        32'h0000_0000,  // 1, invalid
        32'h0000_0000,  // 2, invalid
        32'h0000_0000,  // 3, invalid
        32'h0000_0000,  // 4, invalid
        32'h0000_0009,  // 5:  x^5 + x^3 + 1
        32'h0000_0021,  // 6:  x^6 + x^5 + 1
        32'h0000_0041,  // 7:  x^7 + x^6 + 1
        32'h0000_0071,  // 8:  x^8 + x^6 + x^5 + x^4 + 1
        32'h0000_0021,  // 9:  x^9 + x^5 + 1
        32'h0000_0081,  // 10: x^10 + x^7 + 1
        32'h0000_0201,  // 11
        32'h0000_0053,  // 12
        32'h0000_001B,  // 13
        32'h0000_002B,  // 14
        32'h0000_4001,  // 15
        32'h0000_A011,  // 16
        32'h0000_4001,  // 17
        32'h0000_0801,  // 18
        32'h0000_0047,  // 19
        32'h0002_0001,  // 20
        32'h0008_0001,  // 21
        32'h0020_0001,  // 22
        32'h0004_0001,  // 23
        32'h00C2_0001,  // 24
        32'h0040_0001,  // 25
        32'h0000_0047,  // 26
        32'h0000_0027,  // 27
        32'h0200_0001,  // 28
        32'h0800_0001,  // 29
        32'h0000_0053,  // 30
        32'h1000_0001,  // 31
        32'h0040_0007   // 32
    };

    // pam4 symbol and received sample
    localparam int SYM_W    = 2;
    localparam int SAMPLE_W = 8;

    // fixed slicer decision levels
    localparam logic signed [SAMPLE_W-1:0] THR_LO  = -64;
    localparam logic signed [SAMPLE_W-1:0] THR_MID = 0;
    localparam logic signed [SAMPLE_W-1:0] THR_HI  = 64;

    // per-period bit error count, a 1023 symbol window cannot overflow it
    localparam int ERR_W = 16;

endpackage

/* verilog/sym_slicer.sv */
module sym_slicer import prbs_pkg::*; (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       sample_en,
    input  logic signed [SAMPLE_W-1:0] sample,
    output logic        [SYM_W-1:0]    rx_sym,
    output logic                       rx_valid
);

    logic [SYM_W-1:0] decision;

    // gray order 00, 01, 11, 10 from lowest to highest level
    // neighbouring levels differ in one bit only
    always_comb begin
        if (sample < THR_LO) begin
            decision = 2'b00;
        end else if (sample < THR_MID) begin
            decision = 2'b01;
        end else if (sample < THR_HI) begin
            decision = 2'b11;
        end else begin
            decision = 2'b10;
        end
    end

    // decided symbol is only meaningful with rx_valid
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rx_sym <= '0;
        end else if (sample_en) begin
            rx_sym <= decision;
        end
    end

    // strobe follows the symbol by one cycle
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= sample_en;
        end
    end

endmodule
